/* source/lsuPkg.sv */
`default_nettype none

package lsuPkg;

    localparam int DATA_WIDTH = 32;   // parser logic is written for 32 bits
    localparam int ADDR_WIDTH = 16;   // byte address

    typedef logic [DATA_WIDTH-1:0] dataT;
    typedef logic [ADDR_WIDTH-1:0] addrT;

    // RV32 load/store widths
    typedef enum logic [2:0] {
        opByte         = 3'b000,   // lb / sb
        opHalf         = 3'b001,   // lh / sh
        opWord         = 3'b010,   // lw / sw
        opByteUnsigned = 3'b011,   // lbu
        opHalfUnsigned = 3'b100    // lhu
    } memOpT;

    typedef struct packed {
        logic  isStore;     // 0 means load
        memOpT memOp;
        addrT  addr;        // byte address
        dataT  writeData;   // only low byte/half used for sub-word stores
    } lsuReqT;

    typedef struct packed {
        dataT readData;     // zero for stores and errors
        logic error;        // misaligned or out of range
    } lsuRespT;

endpackage

`default_nettype wire

/* source/loadStoreParser.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreParser (
    input  lsuPkg::memOpT memOp,
    input  logic [1:0]    byteOffset,   // low two bits of the byte address
    input  lsuPkg::dataT  readWord,     // word currently in memory
    input  lsuPkg::dataT  writeData,    // store data, right aligned
    output lsuPkg::dataT  loadData,     // extracted and extended load value
    output lsuPkg::dataT  mergedWord    // word to write back for a store
);

    import lsuPkg::*;

    logic [4:0]  byteShift;   // bit position of addressed byte
    logic [4:0]  halfShift;   // bit position of addressed half
    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    assign byteShift = {byteOffset, 3'b000};
    assign halfShift = {byteOffset[1], 4'b0000};   // halves sit at 0 or 16

    assign byteSel = readWord[byteShift +: 8];
    assign halfSel = readWord[halfShift +: 16];

    // load path
    always_comb begin
        case (memOp)
            opByte: begin
                loadData = {{24{byteSel[7]}}, byteSel};    // sign extend
            end
            opHalf: begin
                loadData = {{16{halfSel[15]}}, halfSel};   // sign extend
            end
            opByteUnsigned: begin
                loadData = {24'b0, byteSel};
            end
            opHalfUnsigned: begin
                loadData = {16'b0, halfSel};
            end
            default: begin
                loadData = readWord;   // full word as stored
            end
        endcase
    end

    // store path, read-modify-write merge
    always_comb begin
        mergedWord = readWord;   // untouched bytes keep their value
        case (memOp)
            opByte, opByteUnsigned: begin
                mergedWord[byteShift +: 8] = writeData[7:0];
            end
            opHalf, opHalfUnsigned: begin
                mergedWord[halfShift +: 16] = writeData[15:0];
            end
            opWord: begin
                mergedWord = writeData;
            end
            default: begin
                mergedWord = readWord;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMemory #(
    parameter int MEM_WORDS_LOG2 = 8
) (
    input  logic                      clk,
    input  logic [MEM_WORDS_LOG2-1:0] readAddr,    // word index
    output lsuPkg::dataT              readWord,    // valid one cycle after readAddr
    input  logic                      writeEn,
    input  logic [MEM_WORDS_LOG2-1:0] writeAddr,   // word index
    input  lsuPkg::dataT              writeData
);

    import lsuPkg::*;

    localparam int MEM_WORDS = 2 ** MEM_WORDS_LOG2;

    dataT mem [MEM_WORDS];

    // memory starts cleared
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
        readWord <= mem[readAddr];   // registered read, old data on collision
    end

endmodule

`default_nettype wire

/* source/lsuControl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsuControl #(
    parameter int MEM_WORDS_LOG2 = 8
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      reqValid,       // one-cycle request strobe
    input  lsuPkg::lsuReqT            req,
    input  lsuPkg::dataT              readWord,       // from memory
    input  lsuPkg::dataT              loadData,       // from parser
    input  lsuPkg::dataT              mergedWord,     // from parser
    output lsuPkg::memOpT             curOp,
    output logic [1:0]                curOffset,
    output lsuPkg::dataT              curWriteData,
    output logic [MEM_WORDS_LOG2-1:0] memReadAddr,
    output logic                      memWriteEn,
    output logic [MEM_WORDS_LOG2-1:0] memWriteAddr,
    output lsuPkg::dataT              memWriteData,
    output logic                      busy,
    output logic                      done,           // one-cycle end pulse
    output lsuPkg::lsuRespT           resp
);

    import lsuPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stRead,        // read address on the memory
        stComplete,    // read word back, parse or merge
        stError
    } stateT;

    stateT  state;
    lsuReqT reqReg;   // request held for its whole lifetime

    logic                  accept;
    logic                  misaligned;
    logic                  outOfRange;
    logic [ADDR_WIDTH-3:0] reqWordIdx;
    logic [MEM_WORDS_LOG2-1:0] curWordIdx;

    // new requests only when fully idle, including the done cycle
    assign busy   = (state != stIdle) || done;
    assign accept = reqValid && !busy;

    // checks on the incoming request
    assign reqWordIdx = req.addr[ADDR_WIDTH-1:2];
    assign outOfRange = (reqWordIdx >> MEM_WORDS_LOG2) != '0;

    always_comb begin
        case (req.memOp)
            opByte, opByteUnsigned: begin
                misaligned = 1'b0;
            end
            opHalf, opHalfUnsigned: begin
                misaligned = req.addr[0];
            end
            opWord: begin
                misaligned = |req.addr[1:0];
            end
            default: begin
                misaligned = 1'b1;   // unknown op treated as bad
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqReg <= req;
        end
    end

    // parser and memory see the held request
    assign curOp        = reqReg.memOp;
    assign curOffset    = reqReg.addr[1:0];
    assign curWriteData = reqReg.writeData;
    assign curWordIdx   = reqReg.addr[MEM_WORDS_LOG2+1:2];

    assign memReadAddr  = curWordIdx;
    assign memWriteAddr = curWordIdx;
    assign memWriteData = mergedWord;
    assign memWriteEn   = (state == stComplete) && reqReg.isStore;   // lands with done

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            done  <= 1'b0;
            resp  <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                stIdle: begin
                    if (accept) begin
                        state <= (misaligned || outOfRange) ? stError : stRead;
                    end
                end
                stRead: begin
                    state <= stComplete;
                end
                stComplete: begin
                    state      <= stIdle;
                    done       <= 1'b1;
                    resp.error <= 1'b0;
                    if (reqReg.isStore) begin
                        resp.readData <= '0;
                    end else begin
                        resp.readData <= loadData;
                    end
                end
                stError: begin
                    state         <= stIdle;
                    done          <= 1'b1;
                    resp.readData <= '0;
                    resp.error    <= 1'b1;   // memory never touched
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/lsuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module lsuTop #(
    parameter int MEM_WORDS_LOG2 = 8
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            reqValid,
    input  lsuPkg::lsuReqT  req,
    output logic            busy,
    output logic            done,
    output lsuPkg::lsuRespT resp
);

    import lsuPkg::*;

    memOpT                     curOp;
    logic [1:0]                curOffset;
    dataT                      curWriteData;
    dataT                      readWord;
    dataT                      loadData;
    dataT                      mergedWord;
    logic [MEM_WORDS_LOG2-1:0] memReadAddr;
    logic                      memWriteEn;
    logic [MEM_WORDS_LOG2-1:0] memWriteAddr;
    dataT                      memWriteData;

    lsuControl #(
        .MEM_WORDS_LOG2(MEM_WORDS_LOG2)
    ) lsuControl_i (
        .clk         (clk),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .req         (req),
        .readWord    (readWord),
        .loadData    (loadData),
        .mergedWord  (mergedWord),
        .curOp       (curOp),
        .curOffset   (curOffset),
        .curWriteData(curWriteData),
        .memReadAddr (memReadAddr),
        .memWriteEn  (memWriteEn),
        .memWriteAddr(memWriteAddr),
        .memWriteData(memWriteData),
        .busy        (busy),
        .done        (done),
        .resp        (resp)
    );

    loadStoreParser loadStoreParser_i (
        .memOp     (curOp),
        .byteOffset(curOffset),
        .readWord  (readWord),
        .writeData (curWriteData),
        .loadData  (loadData),
        .mergedWord(mergedWord)
    );

    dataMemory #(
        .MEM_WORDS_LOG2(MEM_WORDS_LOG2)
    ) dataMemory_i (
        .clk      (clk),
        .readAddr (memReadAddr),
        .readWord (readWord),
        .writeEn  (memWriteEn),
        .writeAddr(memWriteAddr),
        .writeData(memWriteData)
    );

endmodule

`default_nettype wire

/* bench/lsuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsuTb;

    import lsuPkg::*;

    localparam int MEM_WORDS_LOG2 = 8;
    localparam int FIELDS         = 6;    // tokens per line in the tests file
    localparam int MAX_TESTS      = 64;
    localparam int DONE_TIMEOUT   = 20;   // cycles
    localparam int IDLE_TIMEOUT   = 20;   // cycles
    localparam int RESET_CYCLES   = 10;

    logic    clk;
    logic    rstN;
    logic    reqValid;
    lsuReqT  req;
    logic    busy;
    logic    done;
    lsuRespT resp;

    // one token per entry: isStore, memOp, addr, writeData, expReadData, expError
    logic [31:0] testMem [0:MAX_TESTS*FIELDS-1];

    int   numTests;
    int   currentTest;
    int   mismatchCount;
    int   otherCount;      // timing and file problems
    int   timeoutCount;
    logic abortRun;        // DUT stopped responding

    lsuTop #(
        .MEM_WORDS_LOG2(MEM_WORDS_LOG2)
    ) lsuTop_i (
        .clk     (clk),
        .rstN    (rstN),
        .reqValid(reqValid),
        .req     (req),
        .busy    (busy),
        .done    (done),
        .resp    (resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    task automatic checkData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%h, got 0x%h (test %0d)",
                     name, expected, actual, currentTest);
            mismatchCount++;
        end
    endtask

    task automatic checkError(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected 0x%h, got 0x%h (test %0d)",
                     name, expected, actual, currentTest);
            mismatchCount++;
        end
    endtask

    task automatic waitForIdle(output logic timedOut);
        int cycles;
        timedOut = 1'b1;
        for (cycles = 0; cycles < IDLE_TIMEOUT; cycles++) begin
            @(negedge clk);
            if (!busy) begin
                timedOut = 1'b0;
                break;
            end
        end
    endtask

    // returns right after the edge that samples the strobe
    task automatic driveRequest(input lsuReqT request);
        @(posedge clk);
        reqValid <= 1'b1;
        req      <= request;
        @(posedge clk);   // accepting edge
        reqValid <= 1'b0;
        req      <= '0;
    endtask

    // edges counts rising edges from the accepting edge up to done
    task automatic waitForDone(output logic timedOut, output int edges);
        timedOut = 1'b1;
        edges    = 0;
        @(negedge clk);   // half a cycle after acceptance
        checkError("busy", 1'b1, busy);
        while (edges < DONE_TIMEOUT) begin
            @(negedge clk);
            edges++;
            checkError("busy", 1'b1, busy);   // stays high through the done cycle
            if (done) begin
                timedOut = 1'b0;
                break;
            end
        end
    endtask

    task automatic runTest(input int index);
        lsuReqT request;
        dataT   expReadData;
        logic   expError;
        int     expEdges;
        int     edges;
        int     idleCycles;
        int     base;
        logic   timedOut;

        base                = index * FIELDS;
        request.isStore     = testMem[base][0];
        request.memOp       = memOpT'(testMem[base+1][2:0]);
        request.addr        = addrT'(testMem[base+2][15:0]);
        request.writeData   = testMem[base+3];
        expReadData         = testMem[base+4];
        expError            = testMem[base+5][0];
        expEdges            = expError ? 1 : 2;   // error path skips the read
        currentTest         = index;

        waitForIdle(timedOut);
        if (timedOut) begin
            $display("test %0d: busy never fell before the request", index);
            timeoutCount++;
            abortRun = 1'b1;
            return;
        end

        idleCycles = $urandom % 4;
        repeat (idleCycles) @(posedge clk);

        driveRequest(request);
        waitForDone(timedOut, edges);
        if (timedOut) begin
            $display("test %0d: done never asserted", index);
            timeoutCount++;
            abortRun = 1'b1;
            return;
        end

        if (edges != expEdges) begin
            $display("test %0d: done came %0d cycles after the accepting edge instead of %0d",
                     index, edges, expEdges);
            otherCount++;
        end
        checkData("resp.readData", expReadData, resp.readData);
        checkError("resp.error", expError, resp.error);

        @(negedge clk);
        if (done) begin
            $display("test %0d: done stayed high for more than one cycle", index);
            otherCount++;
        end
        checkError("busy", 1'b0, busy);   // busy falls with done
    endtask

    initial begin
        int idx;

        rstN          = 1'b0;
        reqValid      = 1'b0;
        req           = '0;
        numTests      = 0;
        currentTest   = -1;
        mismatchCount = 0;
        otherCount    = 0;
        timeoutCount  = 0;
        abortRun      = 1'b0;

        void'($urandom(46));

        $readmemh("bench/lsuTests.txt", testMem);
        while (numTests < MAX_TESTS && !$isunknown(testMem[numTests*FIELDS])) begin
            numTests++;
        end
        if (numTests == 0) begin
            $display("no test vectors were read from bench/lsuTests.txt");
            otherCount++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        // outputs after reset
        @(negedge clk);
        checkError("busy", 1'b0, busy);
        checkError("done", 1'b0, done);
        checkData("resp.readData", '0, resp.readData);
        checkError("resp.error", 1'b0, resp.error);

        for (idx = 0; idx < numTests; idx++) begin
            if (abortRun) begin
                break;
            end
            runTest(idx);
        end

        $display("%0d tests run: %0d mismatches, %0d other errors, %0d timeouts",
                 numTests, mismatchCount, otherCount, timeoutCount);
        if (mismatchCount == 0 && otherCount == 0 && timeoutCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/lsuTests.txt */
// columns: isStore memOp addr writeData expReadData expError (all hex)
// memOp: 0 byte, 1 half, 2 word, 3 byte unsigned, 4 half unsigned
// cleared memory after reset
0 2 0000 00000000 00000000 0
0 2 03FC 00000000 00000000 0
0 2 0120 00000000 00000000 0
// word store then word load
1 2 0010 DEADBEEF 00000000 0
0 2 0010 00000000 DEADBEEF 0
1 2 03FC 12345678 00000000 0
0 2 03FC 00000000 12345678 0
// byte stores at offsets 0 to 3
1 2 0020 11223344 00000000 0
1 0 0020 000000AA 00000000 0
0 2 0020 00000000 112233AA 0
1 0 0021 000000BB 00000000 0
0 2 0020 00000000 1122BBAA 0
1 0 0022 FFFFFFCC 00000000 0
0 2 0020 00000000 11CCBBAA 0
1 0 0023 123456DD 00000000 0
0 2 0020 00000000 DDCCBBAA 0
// signed and unsigned sub-word loads
1 2 0030 85F07F92 00000000 0
0 0 0030 00000000 FFFFFF92 0
0 3 0030 00000000 00000092 0
0 0 0031 00000000 0000007F 0
0 0 0032 00000000 FFFFFFF0 0
0 3 0033 00000000 00000085 0
0 0 0033 00000000 FFFFFF85 0
0 1 0032 00000000 FFFF85F0 0
0 4 0032 00000000 000085F0 0
0 1 0030 00000000 00007F92 0
0 4 0030 00000000 00007F92 0
// half stores at offsets 0 and 2
1 2 0040 CAFEF00D 00000000 0
1 1 0040 00009ABC 00000000 0
0 1 0040 00000000 FFFF9ABC 0
0 2 0040 00000000 CAFE9ABC 0
1 1 0042 ABCD1234 00000000 0
0 4 0042 00000000 00001234 0
0 2 0040 00000000 12349ABC 0
// misaligned and out of range requests leave memory alone
1 2 0050 5A5A5A5A 00000000 0
1 1 0051 0000FFFF 00000000 1
0 2 0050 00000000 5A5A5A5A 0
1 2 0052 FFFFFFFF 00000000 1
0 2 0050 00000000 5A5A5A5A 0
0 1 0053 00000000 00000000 1
0 2 0051 00000000 00000000 1
1 2 0400 FFFFFFFF 00000000 1
0 2 0000 00000000 00000000 0
1 0 8003 000000EE 00000000 1
0 2 0000 00000000 00000000 0
0 1 0402 00000000 00000000 1

/* src.f */
source/lsuPkg.sv
source/loadStoreParser.sv
source/dataMemory.sv
source/lsuControl.sv
source/lsuTop.sv
bench/lsuTb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - source/lsuPkg.sv
  - source/loadStoreParser.sv
  - source/dataMemory.sv
  - source/lsuControl.sv
  - source/lsuTop.sv
  - target: test
    files:
      - bench/lsuTb.sv
